//--- files.f
src/ramio_pkg.sv
src/word_ram.sv
src/uart_rx.sv
src/uart_tx.sv
src/ramio.sv
dv/ramio_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ramio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ramio_tb -f files.f -o ramio_sim

# the log decides pass or fail
./obj_dir/ramio_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- dv/ramio_tb.sv
//////////////////////////////////////////////////////////////////////
// ramio testbench
// random RAM traffic against a byte shadow, LED register checks and
// UART transmit looped back into the receiver
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ramio_tb
  import ramio_pkg::*;
();

  localparam int unsigned num_words      = 16;
  localparam int unsigned num_lane_words = 4;
  localparam int unsigned num_uart       = 4;
  // accesses over reset reads, round trip, lanes, LEDs, UART and final rereads
  localparam int unsigned num_accesses = 3 + 2 * num_words + 21 * num_lane_words + 4 +
                                         5 * num_uart + num_words + num_lane_words;
  localparam int unsigned watchdog_cycles = num_accesses * 4 +
                                            num_uart * 12 * clocks_per_bit + 100;

  logic                  clk;
  logic                  rst_n;
  logic                  enable;
  logic [2:0]            read_type;
  logic [1:0]            write_type;
  logic [addr_width-1:0] address;
  logic [data_width-1:0] data_in;
  wire  [data_width-1:0] data_out;
  wire                   data_out_ready;
  wire  [3:0]            led;
  // tx looped straight back to rx
  wire                   uart_line;

  // expected values set together with the inputs
  logic                  check_rd;
  logic [data_width-1:0] exp_data;
  logic [3:0]            led_exp;
  logic [7:0]            tx_byte;
  logic                  io_sel;

  // byte image of the RAM indexed by the low ten address bits
  logic [7:0] shadow [4 * 2**ram_word_bits];
  bit         word_valid [2**ram_word_bits];
  logic [31:0] rng;

  // one counter per checker
  int data_errors      = 0;
  int latency_errors   = 0;
  int io_ready_errors  = 0;
  int led_errors       = 0;
  int frame_errors     = 0;
  int handshake_errors = 0;
  int accesses         = 0;
  int frames_seen      = 0;

  assign io_sel = (address == addr_led) || (address == addr_uart_out) ||
                  (address == addr_uart_in);

  ramio i_ramio (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (uart_line),
    .uart_rx        (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic int error_total();
    return data_errors + latency_errors + io_ready_errors + led_errors +
           frame_errors + handshake_errors;
  endfunction

  // narrowed RAM read built from the shadow bytes
  function automatic logic [31:0] expected_read(input logic [31:0] a, input logic [2:0] rt);
    logic [9:0]  i;
    logic [7:0]  b;
    logic [15:0] h;
    i = a[9:0];
    b = shadow[i];
    h = {shadow[{i[9:1], 1'b1}], shadow[{i[9:1], 1'b0}]};
    case (rt[1:0])
      read_byte: return rt[2] ? {{24{b[7]}}, b} : {24'h0, b};
      read_half: begin
        // odd address reads as zero
        if (i[0]) return 32'h0;
        return rt[2] ? {{16{h[15]}}, h} : {16'h0, h};
      end
      read_word: return {shadow[{i[9:2], 2'd3}], shadow[{i[9:2], 2'd2}],
                         shadow[{i[9:2], 2'd1}], shadow[{i[9:2], 2'd0}]};
      default:   return 32'h0;
    endcase
  endfunction

  task automatic print_summary();
    $write("summary: %0d accesses, %0d frames, ", accesses, frames_seen);
    $display("errors data %0d latency %0d io %0d led %0d frame %0d handshake %0d",
             data_errors, latency_errors, io_ready_errors,
             led_errors, frame_errors, handshake_errors);
  endtask

  // drive one access on a falling edge and hold it through one ready edge
  task automatic access(input logic [31:0] a, input logic [2:0] rt, input logic [1:0] wt,
                        input logic [31:0] wd, input logic chk, input logic [31:0] expv);
    int waited;
    enable     = 1'b1;
    address    = a;
    read_type  = rt;
    write_type = wt;
    data_in    = wd;
    check_rd   = chk;
    exp_data   = expv;
    accesses++;
    waited = 0;
    #1;
    while (!data_out_ready && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!data_out_ready) begin
      $display("access to %h never raised data_out_ready (time %0t)", a, $time);
      handshake_errors++;
    end
    @(negedge clk);
    if (wt != write_none && a == addr_led) led_exp = wd[3:0];
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = write_none;
    check_rd   = 1'b0;
    // idle cycle so ready falls before the next access
    @(negedge clk);
  endtask

  task automatic ram_write(input logic [31:0] a, input logic [1:0] wt, input logic [31:0] wd);
    logic [9:0] i;
    i = a[9:0];
    access(a, 3'b000, wt, wd, 1'b0, 32'h0);
    case (wt)
      write_byte: shadow[i] = wd[7:0];
      write_half: begin
        if (!i[0]) begin
          shadow[{i[9:1], 1'b0}] = wd[7:0];
          shadow[{i[9:1], 1'b1}] = wd[15:8];
        end
      end
      write_word: begin
        for (int k = 0; k < 4; k++) shadow[{i[9:2], 2'(k)}] = wd[8*k +: 8];
        word_valid[i[9:2]] = 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic ram_read(input logic [31:0] a, input logic [2:0] rt);
    access(a, rt, write_none, 32'h0, 1'b1, expected_read(a, rt));
  endtask

  task automatic io_read(input logic [31:0] a, input logic [31:0] expv);
    access(a, {1'b0, read_word}, write_none, 32'h0, 1'b1, expv);
  endtask

  task automatic io_write(input logic [31:0] a, input logic [31:0] d);
    access(a, 3'b000, write_word, d, 1'b0, 32'h0);
  endtask

  // send one byte and pick it up again from the receive register
  task automatic uart_loop(input logic [31:0] d);
    int target;
    target  = frames_seen + 1;
    tx_byte = d[7:0];
    io_write(addr_uart_out, d);
    io_read(addr_uart_out, {24'h0, d[7:0]});
    wait (frames_seen >= target);
    // rest of the stop bit plus the register handoff
    repeat (clocks_per_bit) @(negedge clk);
    io_read(addr_uart_out, io_idle);
    io_read(addr_uart_in, {24'h0, d[7:0]});
    io_read(addr_uart_in, io_idle);
  endtask

  a_read_data : assert property (
    @(posedge clk) disable iff (!rst_n)
    check_rd && data_out_ready |-> data_out == exp_data
  ) else begin
    $display("error %0t: read of %h returned %h, expected %h", $time,
             $sampled(address), $sampled(data_out), $sampled(exp_data));
    data_errors++;
  end

  // RAM answers on the second edge and never on the first
  a_ram_latency : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(enable) && !io_sel |-> !data_out_ready ##1 data_out_ready
  ) else begin
    $display("error %0t: data_out_ready not one cycle after enable", $time);
    latency_errors++;
  end

  a_io_ready : assert property (
    @(posedge clk) disable iff (!rst_n) enable && io_sel |-> data_out_ready
  ) else begin
    $display("error %0t: I/O access without same-cycle ready", $time);
    io_ready_errors++;
  end

  a_led : assert property (
    @(posedge clk) disable iff (!rst_n) led == led_exp
  ) else begin
    $display("error %0t: led %b, expected %b", $time, $sampled(led), $sampled(led_exp));
    led_errors++;
  end

  // decode uart_tx at mid-bit
  initial begin : frame_monitor
    logic [7:0] got;
    logic       start_ok;
    logic       stop_ok;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (uart_line == 1'b0) begin
        repeat (clocks_per_bit / 2 - 1) @(negedge clk);
        start_ok = (uart_line == 1'b0);
        for (int k = 0; k < 8; k++) begin
          repeat (clocks_per_bit) @(negedge clk);
          got[k] = uart_line;
        end
        repeat (clocks_per_bit) @(negedge clk);
        stop_ok = uart_line;
        a_frame : assert (start_ok && stop_ok && got == tx_byte) else begin
          $display("error %0t: frame %h start %b stop %b, expected %h", $time,
                   got, start_ok, stop_ok, tx_byte);
          frame_errors++;
        end
        frames_seen++;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] addrs [num_words];
    logic [31:0] a;
    rng        = 32'h6e23;
    rst_n      = 1'b0;
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = write_none;
    address    = 32'h0;
    data_in    = 32'h0;
    check_rd   = 1'b0;
    exp_data   = 32'h0;
    led_exp    = 4'hf;
    tx_byte    = 8'h00;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // registers at rest
    io_read(addr_uart_out, io_idle);
    io_read(addr_uart_in, io_idle);
    io_read(addr_led, 32'hf);

    // word round trip where the first words alias the low bits of the I/O addresses
    for (int n = 0; n < num_words; n++) begin
      addrs[n] = next_random() & 32'h00ff_03fc;
      if (n < 3) addrs[n] = 32'h0000_03fc - 32'(4 * n);
      ram_write(addrs[n], write_word, next_random());
    end
    for (int n = 0; n < num_words; n++) ram_read(addrs[n], {1'b0, read_word});

    // byte and half lanes with both extensions
    for (int n = 0; n < num_lane_words; n++) begin
      a = next_random() & 32'h00ff_03fc;
      ram_write(a, write_word, next_random());
      for (int k = 0; k < 4; k++) ram_write(a | 32'(k), write_byte, next_random());
      for (int k = 0; k < 4; k++) begin
        ram_read(a | 32'(k), {1'b0, read_byte});
        ram_read(a | 32'(k), {1'b1, read_byte});
      end
      ram_write(a | (next_random() & 32'h2), write_half, next_random());
      // odd half write is dropped
      ram_write(a | (next_random() & 32'h2) | 32'h1, write_half, next_random());
      for (int k = 0; k < 4; k += 2) begin
        ram_read(a | 32'(k), {1'b0, read_half});
        ram_read(a | 32'(k), {1'b1, read_half});
      end
      ram_read(a | 32'h1, {1'b1, read_half});
      ram_read(a, {1'b0, read_word});
    end

    // LEDs
    for (int n = 0; n < 2; n++) begin
      io_write(addr_led, next_random());
      io_read(addr_led, {28'h0, led_exp});
    end

    // UART loopback
    for (int n = 0; n < num_uart; n++) uart_loop(next_random());

    // every written word survives the I/O traffic
    for (int w = 0; w < 2**ram_word_bits; w++) begin
      if (word_valid[w]) ram_read(32'(w) << 2, {1'b0, read_word});
    end

    @(negedge clk);
    if (frames_seen != num_uart) begin
      $display("saw %0d frames on uart_tx instead of %0d", frames_seen, num_uart);
      handshake_errors++;
    end
    print_summary();
    if (error_total() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("run timed out after %0d cycles", watchdog_cycles);
    print_summary();
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/ramio.sv
//////////////////////////////////////////////////////////////////////
// memory-mapped I/O bridge
// routes client accesses to word RAM or to UART and LED registers,
// converts byte and half accesses to byte-enabled word accesses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ramio
  import ramio_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   enable,
  input  wire  [2:0]            read_type,
  input  wire  [1:0]            write_type,
  input  wire  [addr_width-1:0] address,
  input  wire  [data_width-1:0] data_in,
  output logic [data_width-1:0] data_out,
  output logic                  data_out_ready,
  output logic [3:0]            led,
  output logic                  uart_tx,
  input  wire                   uart_rx
);

  // address decode
  logic is_led;
  logic is_tx;
  logic is_rx;
  logic is_io;
  logic is_read;
  logic is_write;

  // word RAM side
  logic [3:0]            ram_we;
  logic [data_width-1:0] ram_wdata;
  logic [data_width-1:0] ram_rdata;
  logic                  ram_ready;

  // read lane selection
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  // UART registers, io_idle when nothing pending
  logic [data_width-1:0] tx_send;
  logic [data_width-1:0] rx_recv;
  logic                  tx_go;
  logic                  tx_go_prev;
  logic                  tx_busy;
  logic                  rx_go;
  logic                  rx_ready;
  logic [7:0]            rx_data;

  assign is_led   = (address == addr_led);
  assign is_tx    = (address == addr_uart_out);
  assign is_rx    = (address == addr_uart_in);
  assign is_io    = is_led || is_tx || is_rx;
  assign is_read  = enable && (read_type[1:0] != read_none);
  assign is_write = enable && (write_type != write_none);

  // I/O answers in the same cycle, RAM one cycle later
  assign data_out_ready = is_io ? 1'b1 : ram_ready;

  // write lanes, data is replicated and the enables pick the lanes
  always_comb begin
    ram_we    = '0;
    ram_wdata = data_in;
    case (write_type)
      write_byte: begin
        ram_we    = 4'b0001 << address[1:0];
        ram_wdata = {4{data_in[7:0]}};
      end
      write_half: begin
        // misaligned half leaves every lane alone
        if (!address[0]) ram_we = address[1] ? 4'b1100 : 4'b0011;
        ram_wdata = {2{data_in[15:0]}};
      end
      write_word: ram_we = 4'b1111;
      default:    ram_we = '0;
    endcase
  end

  // read narrowing and extension
  always_comb begin
    rd_byte  = ram_rdata[{address[1:0], 3'b000} +: 8];
    rd_half  = ram_rdata[{address[1], 4'b0000} +: 16];
    data_out = '0;
    if (is_tx) begin
      data_out = tx_send;
    end else if (is_rx) begin
      data_out = rx_recv;
    end else if (is_led) begin
      data_out = {{(data_width-4){1'b0}}, led};
    end else begin
      case (read_type[1:0])
        read_byte: data_out = {{(data_width-8){read_type[2] & rd_byte[7]}}, rd_byte};
        read_half: begin
          if (!address[0]) begin
            data_out = {{(data_width-16){read_type[2] & rd_half[15]}}, rd_half};
          end
        end
        read_word: data_out = ram_rdata;
        default:   data_out = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_send    <= io_idle;
      tx_go      <= 1'b0;
      tx_go_prev <= 1'b0;
      rx_recv    <= io_idle;
      rx_go      <= 1'b1;
      led        <= 4'b1111;
    end else begin
      tx_go_prev <= 1'b0;
      // a CPU read wins, the received byte waits a cycle
      if (is_read && is_rx) begin
        rx_recv <= io_idle;
      end else if (rx_go && rx_ready) begin
        // overrun just overwrites
        rx_recv <= {{(data_width-8){1'b0}}, rx_data};
        rx_go   <= 1'b0;
      end
      // one-cycle acknowledge, then listen again
      if (!rx_go) rx_go <= 1'b1;
      // busy shows up one edge after go, so skip that first cycle
      if (tx_go && !tx_busy && !tx_go_prev) begin
        tx_go   <= 1'b0;
        tx_send <= io_idle;
      end
      if (is_write && is_tx) begin
        tx_send    <= {{(data_width-8){1'b0}}, data_in[7:0]};
        tx_go      <= 1'b1;
        tx_go_prev <= 1'b1;
      end
      if (is_write && is_led) led <= data_in[3:0];
    end
  end

  word_ram i_word_ram (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable && !is_io),
    .word_addr      (address[ram_word_bits+1:2]),
    .write_enable   (ram_we),
    .data_in        (ram_wdata),
    .data_out       (ram_rdata),
    .data_out_ready (ram_ready)
  );

  uart_tx i_uart_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (tx_send[7:0]),
    .tx    (uart_tx),
    .busy  (tx_busy)
  );

  uart_rx i_uart_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_ready)
  );

  a_single_access : assert property (
    @(posedge clk) disable iff (!rst_n)
    enable |-> !(read_type != '0 && write_type != write_none)
  ) else $error("ramio: read and write requested together");

  // a new send must never start on top of a frame in flight
  a_tx_go_idle : assert property (
    @(posedge clk) disable iff (!rst_n) $rose(tx_go) |-> !tx_busy
  ) else $error("ramio: uart_tx go raised while busy");

endmodule

`default_nettype wire

//--- src/uart_tx.sv
//////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1
// one frame per go request, busy while the frame is on the line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import ramio_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        go,
  input  wire  [7:0] data,
  output logic       tx,
  output logic       busy
);

  localparam int unsigned cnt_w = $clog2(clocks_per_bit);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clocks_per_bit - 1);

  logic [cnt_w-1:0] cyc;
  logic [3:0]       bit_cnt;
  logic [8:0]       shift;
  logic             armed;
  logic             start;
  logic             bit_end;

  // a new frame needs go to have been low since the last one
  assign start   = !busy && go && armed;
  assign bit_end = busy && (cyc == last_cnt);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      armed   <= 1'b1;
      cyc     <= '0;
      bit_cnt <= '0;
    end else begin
      if (!go) armed <= 1'b1;
      if (start) begin
        // start bit goes out right away
        busy    <= 1'b1;
        armed   <= 1'b0;
        tx      <= 1'b0;
        cyc     <= '0;
        bit_cnt <= '0;
      end else if (bit_end) begin
        cyc <= '0;
        if (bit_cnt == 4'd9) begin
          // end of stop bit, back to idle
          busy <= 1'b0;
          tx   <= 1'b1;
        end else begin
          tx      <= shift[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (busy) begin
        cyc <= cyc + 1'b1;
      end
    end
  end

  // byte plus stop bit, shifted LSB first
  always_ff @(posedge clk) begin
    if (start) begin
      shift <= {1'b1, data};
    end else if (bit_end && bit_cnt != 4'd9) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

  a_idle_line_high : assert property (
    @(posedge clk) disable iff (!rst_n) !busy |-> tx
  ) else $error("uart_tx: line low while idle");

endmodule

`default_nettype wire

//--- src/uart_rx.sv
//////////////////////////////////////////////////////////////////////
// UART receiver, 8N1
// samples mid-bit, holds the byte until go drops as acknowledge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import ramio_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int unsigned cnt_w = $clog2(clocks_per_bit);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clocks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clocks_per_bit / 2 - 1);

  typedef enum logic [2:0] {st_idle, st_start, st_data, st_stop, st_done} state_t;

  state_t           state;
  logic             rx_meta;
  logic             rx_sync;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic             bit_end;

  // mid-bit point of a data bit
  assign bit_end = (cnt == last_cnt);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      state      <= st_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      // two-flop synchronizer, line idles high
      rx_meta <= rx;
      rx_sync <= rx_meta;
      cnt     <= cnt + 1'b1;
      case (state)
        st_idle: begin
          cnt <= '0;
          if (go && !rx_sync) state <= st_start;
        end
        st_start: begin
          // recheck in the middle of the start bit
          if (cnt == half_cnt) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? st_idle : st_data;
          end
        end
        st_data: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= st_stop;
          end
        end
        st_stop: begin
          // framing error drops the byte
          if (bit_end) begin
            cnt        <= '0;
            data_ready <= rx_sync;
            state      <= rx_sync ? st_done : st_idle;
          end
        end
        default: begin
          // wait for the acknowledge
          if (!go) begin
            data_ready <= 1'b0;
            state      <= st_idle;
          end
        end
      endcase
    end
  end

  // data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state == st_data && bit_end) data <= {rx_sync, data[7:1]};
  end

endmodule

`default_nettype wire

//--- src/word_ram.sv
//////////////////////////////////////////////////////////////////////
// byte-enabled word RAM
// registered read, ready strobe one cycle after enable
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module word_ram
  import ramio_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      enable,
  input  wire  [ram_word_bits-1:0] word_addr,
  input  wire  [3:0]               write_enable,
  input  wire  [data_width-1:0]    data_in,
  output logic [data_width-1:0]    data_out,
  output logic                     data_out_ready
);

  // storage, no reset on the array
  logic [data_width-1:0] mem [2**ram_word_bits];

  // byte lane writes and registered read
  always_ff @(posedge clk) begin
    if (enable) begin
      for (int b = 0; b < 4; b++) begin
        if (write_enable[b]) begin
          mem[word_addr][8*b +: 8] <= data_in[8*b +: 8];
        end
      end
      // read returns the word before this edge's write
      data_out <= mem[word_addr];
    end
  end

  // ready follows enable by one clock, fixed latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out_ready <= 1'b0;
    end else begin
      data_out_ready <= enable;
    end
  end

  // byte enables come from the lane aligner in ramio
  // only byte, aligned half or full word patterns are legal
  a_write_enable_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    enable |-> ($onehot0(write_enable) ||
                write_enable inside {4'b0011, 4'b1100, 4'b1111})
  ) else $error("word_ram: illegal write_enable %b", write_enable);

endmodule

`default_nettype wire

//--- src/ramio_pkg.sv
//////////////////////////////////////////////////////////////////////
// ramio shared definitions
// address map, RAM geometry, UART bit timing and access-type codes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package ramio_pkg;

  // client and RAM data path
  localparam int unsigned data_width = 32;
  localparam int unsigned addr_width = 32;

  // 256 words of local RAM
  localparam int unsigned ram_word_bits = 8;

  // I/O registers at the top of the address space
  // led: 0 is on, 1 is off
  localparam logic [addr_width-1:0] addr_led      = 32'hffff_fffc;
  localparam logic [addr_width-1:0] addr_uart_out = 32'hffff_fff8;
  localparam logic [addr_width-1:0] addr_uart_in  = 32'hffff_fff4;

  // short bit time, sized for simulation
  localparam int unsigned clocks_per_bit = 8;

  // low two bits of read_type, bit 2 asks for sign extension
  localparam logic [1:0] read_none = 2'b00;
  localparam logic [1:0] read_byte = 2'b01;
  localparam logic [1:0] read_half = 2'b10;
  localparam logic [1:0] read_word = 2'b11;

  // write_type codes
  localparam logic [1:0] write_none = 2'b00;
  localparam logic [1:0] write_byte = 2'b01;
  localparam logic [1:0] write_half = 2'b10;
  localparam logic [1:0] write_word = 2'b11;

  // idle UART register reads back as -1
  localparam logic [data_width-1:0] io_idle = '1;

endpackage

`default_nettype wire
